/* hw/cart_map_pkg.sv */
// Types and constants for the cartridge bank mapper
// Imported by the mapper and the top level for bank, mask and register window widths

package cart_map_pkg;

	//////////////////////////////////////////////////
	// Bank registers

	localparam int BANK_W     = 5;  // 512 KB banks, up to 16 MB
	localparam int BANK_COUNT = 8;  // One slot per 512 KB of CPU space

	typedef logic [23:1]  cpu_addr_t;    // 68k word address
	typedef logic [23:13] rom_mask_t;    // Size mask above the 8 KB granule
	typedef logic [2:0]   reg_offset_t;  // Word offset in the time-register window

	//////////////////////////////////////////////////
	// Register window offsets used by the protected cart

	localparam reg_offset_t OFS_EEPROM    = 3'd4;  // Pin write
	localparam reg_offset_t OFS_EEPROM_SO = 3'd5;  // Serial out read back

	// One write word, read as a bank number or as the EEPROM pin set
	typedef union packed {
		struct packed {
			logic [15-BANK_W:0] rsvd;
			logic [BANK_W-1:0]  bank;
		} bank_view;
		struct packed {
			logic [11:0] rsvd;
			logic        cs;    // Active low
			logic        hold;  // Active low
			logic        sck;
			logic        si;
		} pin_view;
	} treg_word_u;

endpackage

/* hw/rom_header_pkg.sv */
// Header offsets, region letters and cart identity constants
// Used by the download snooper and by the protection hook

package rom_header_pkg;

	typedef enum logic [1:0] {
		JP = 2'd0,
		US = 2'd1,
		EU = 2'd2
	} region_t;

	//////////////////////////////////////////////////
	// Header byte addresses in the image

	localparam logic [23:0] HDR_REGION_ADDR = 24'h0001F0;  // Region letter in low byte
	localparam logic [23:0] HDR_ID_FIRST    = 24'h000182;  // First identity word
	localparam logic [23:0] HDR_ID_DONE     = 24'h00018C;  // Identity complete here

	localparam logic [7:0] REGION_LETTER_JP = 8'h4A;  // "J"
	localparam logic [7:0] REGION_LETTER_US = 8'h55;  // "U"

	typedef logic [63:0] cart_id_t;  // Eight ASCII characters

	// Known protected cart, two pressings
	localparam cart_id_t PIER_ID_REPRINT = "T-574023";
	localparam cart_id_t PIER_ID_FIRST   = "T-574013";

	//////////////////////////////////////////////////
	// Protection read hook

	localparam logic [23:0] PIER_HOOK_ADDR_LO = 24'h0015E6;
	localparam logic [23:0] PIER_HOOK_ADDR_HI = 24'h0015E8;
	localparam int          PIER_EARLY_HITS   = 6;  // Hits before the late answer

	localparam logic [15:0] PIER_EARLY_LO = 16'h0000;
	localparam logic [15:0] PIER_EARLY_HI = 16'h0010;
	localparam logic [15:0] PIER_LATE_LO  = 16'h0001;
	localparam logic [15:0] PIER_LATE_HI  = 16'h8010;

endpackage

/* hw/rom_header_snoop.sv */
`timescale 1ns/100ps
// Download port slave that watches the ROM image as it streams in
// Picks out region, protected cart identity, ROM size mask and cart or BIOS mode

module rom_header_snoop (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    dl_cyc,
	input  logic                    dl_stb,
	input  logic                    dl_we,
	input  logic [23:0]             dl_adr,
	input  logic [15:0]             dl_dat,
	input  logic                    dl_active,
	input  logic                    dl_cart,
	output logic                    dl_ack,
	output rom_header_pkg::region_t region,
	output logic                    pier_quirk,
	output logic                    cart_mode,
	output cart_map_pkg::rom_mask_t rom_mask
);
	import rom_header_pkg::*;

	logic     req_seen;     // Set until stb drops
	logic     req_new;
	logic     wr_take;
	logic     dl_active_q;
	cart_id_t cart_id;      // Byte swapped identity

	assign req_new = dl_cyc && dl_stb && !req_seen;
	assign wr_take = req_new && dl_we && dl_active;

	// Wishbone classic handshake, one ack per request
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_ack   <= 1'b0;
			req_seen <= 1'b0;
		end else begin
			dl_ack <= req_new;
			if (req_new)
				req_seen <= 1'b1;
			else if (!dl_stb)
				req_seen <= 1'b0;
		end
	end

	//////////////////////////////////////////////////
	// Header fields

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			region      <= JP;
			pier_quirk  <= 1'b0;
			cart_mode   <= 1'b0;
			rom_mask    <= '0;
			dl_active_q <= 1'b0;
		end else begin
			dl_active_q <= dl_active;
			if (dl_active && !dl_active_q)
				pier_quirk <= 1'b0;  // New image, forget the old cart

			if (wr_take) begin
				cart_mode <= dl_cart;
				if (dl_cart)  // Address 0 restarts the size scan
					rom_mask <= (dl_adr == '0) ? '0 : (rom_mask | dl_adr[23:13]);

				if (dl_adr == HDR_REGION_ADDR) begin
					if (dl_dat[7:0] == REGION_LETTER_JP)
						region <= JP;
					else if (dl_dat[7:0] == REGION_LETTER_US)
						region <= US;
					else
						region <= EU;
				end

				if (dl_cart && dl_adr == HDR_ID_DONE &&
					(cart_id == PIER_ID_REPRINT || cart_id == PIER_ID_FIRST))
					pier_quirk <= 1'b1;
			end
		end
	end

	// Identity string, download words arrive low byte first
	always_ff @(posedge clk_sys) begin
		if (wr_take && dl_cart) begin
			case (dl_adr)
				HDR_ID_FIRST:         cart_id[63:56] <= dl_dat[15:8];
				HDR_ID_FIRST + 24'd2: cart_id[55:40] <= {dl_dat[7:0], dl_dat[15:8]};
				HDR_ID_FIRST + 24'd4: cart_id[39:24] <= {dl_dat[7:0], dl_dat[15:8]};
				HDR_ID_FIRST + 24'd6: cart_id[23:8]  <= {dl_dat[7:0], dl_dat[15:8]};
				HDR_ID_FIRST + 24'd8: cart_id[7:0]   <= dl_dat[7:0];
				default: ;
			endcase
		end
	end

endmodule

/* hw/bank_mapper.sv */
`timescale 1ns/100ps
// Time-register window slave holding the 512 KB bank registers and EEPROM pins
// Translates CPU word addresses into ROM word addresses, combinationally

module bank_mapper (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      tr_cyc,
	input  logic                      tr_stb,
	input  logic                      tr_we,
	input  cart_map_pkg::reg_offset_t tr_adr,
	input  cart_map_pkg::treg_word_u  tr_dat_w,
	output logic [15:0]               tr_dat_r,
	output logic                      tr_ack,
	input  logic                      dl_active,
	input  logic                      pier_quirk,
	input  cart_map_pkg::rom_mask_t   rom_mask,
	input  cart_map_pkg::cpu_addr_t   cpu_addr,
	output cart_map_pkg::cpu_addr_t   rom_addr,
	input  logic                      eeprom_so,
	output logic                      eeprom_cs,
	output logic                      eeprom_hold,
	output logic                      eeprom_sck,
	output logic                      eeprom_si
);
	import cart_map_pkg::*;

	logic              req_seen;
	logic              req_new;
	logic              wr_take;
	logic              std_mapper;
	logic [BANK_W-1:0] bank_reg [BANK_COUNT];

	assign req_new = tr_cyc && tr_stb && !req_seen;
	assign wr_take = req_new && tr_we;

	// Banking only for images over 4 MB, unless the protected cart owns the window
	assign std_mapper = (rom_mask[23:22] != 2'b00) && !pier_quirk;

	//////////////////////////////////////////////////
	// Bus handshake and read back

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			tr_ack   <= 1'b0;
			req_seen <= 1'b0;
		end else begin
			tr_ack <= req_new;
			if (req_new)
				req_seen <= 1'b1;
			else if (!tr_stb)
				req_seen <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (req_new) begin
			tr_dat_r <= 16'hFFFF;  // Open bus
			if (pier_quirk && tr_adr == OFS_EEPROM_SO)
				tr_dat_r[0] <= eeprom_so;
		end
	end

	//////////////////////////////////////////////////
	// Bank registers

	always_ff @(posedge clk_sys) begin
		if (reset || dl_active) begin
			for (int i = 0; i < BANK_COUNT; i++)
				bank_reg[i] <= BANK_W'(i);  // Identity map
		end else if (wr_take) begin
			if (pier_quirk) begin
				// Offsets 1 to 3 reach banks 5 to 7
				if (tr_adr != '0 && !tr_adr[2])
					bank_reg[{1'b1, tr_adr[1:0]}] <= {1'b0, tr_dat_w.bank_view.bank[3:0]};
			end else if (std_mapper && tr_adr != '0) begin
				bank_reg[tr_adr] <= tr_dat_w.bank_view.bank;  // Slot 0 is fixed
			end
		end
	end

	// EEPROM pin register, idle high
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			eeprom_cs   <= 1'b1;
			eeprom_hold <= 1'b1;
			eeprom_sck  <= 1'b1;
			eeprom_si   <= 1'b1;
		end else if (wr_take && pier_quirk && tr_adr == OFS_EEPROM) begin
			eeprom_cs   <= tr_dat_w.pin_view.cs;
			eeprom_hold <= tr_dat_w.pin_view.hold;
			eeprom_sck  <= tr_dat_w.pin_view.sck;
			eeprom_si   <= tr_dat_w.pin_view.si;
		end
	end

	// Slot from bits 21:19, offset inside the bank kept, folded by image size
	assign rom_addr = {bank_reg[cpu_addr[21:19]], cpu_addr[18:1]} & {rom_mask, 12'hFFF};

endmodule

/* hw/pier_protect.sv */
`timescale 1ns/100ps
// Copy-protection read hook of the protected cart
// Replaces ROM data at two fixed addresses, answer changes after a few hits

module pier_protect (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    dl_active,
	input  logic                    pier_quirk,
	input  logic                    cpu_strobe,
	input  cart_map_pkg::cpu_addr_t cpu_addr,
	input  logic [15:0]             rom_data_in,
	output logic [15:0]             rom_data_out
);
	import rom_header_pkg::*;

	logic [23:0] byte_addr;
	logic        hook_hit;
	logic        hook_on;
	logic [2:0]  hit_count;  // Saturates at the early hit limit
	logic [15:0] hook_data;

	assign byte_addr = {cpu_addr, 1'b0};
	assign hook_hit  = (byte_addr == PIER_HOOK_ADDR_LO) || (byte_addr == PIER_HOOK_ADDR_HI);

	always_ff @(posedge clk_sys) begin
		if (reset || dl_active) begin
			hook_on   <= 1'b0;
			hit_count <= '0;
		end else if (pier_quirk && cpu_strobe) begin
			hook_on <= hook_hit;  // Decision held until next access
			if (hook_hit && hit_count < 3'(PIER_EARLY_HITS))
				hit_count <= hit_count + 3'd1;
		end
	end

	// Word at 0x15E6 has bit 1 set, 0x15E8 does not
	always_ff @(posedge clk_sys) begin
		if (pier_quirk && cpu_strobe && hook_hit) begin
			if (hit_count < 3'(PIER_EARLY_HITS))
				hook_data <= cpu_addr[1] ? PIER_EARLY_LO : PIER_EARLY_HI;
			else
				hook_data <= cpu_addr[1] ? PIER_LATE_LO : PIER_LATE_HI;
		end
	end

	assign rom_data_out = hook_on ? hook_data : rom_data_in;

endmodule

/* hw/cart_mapper_top.sv */
`timescale 1ns/100ps
// Cartridge mapping block of the console core
// Header snooper feeds the bank mapper, protection hook sits on the ROM data path

module cart_mapper_top (
	input  logic                      clk_sys,
	input  logic                      reset,
	// Download port
	input  logic                      dl_cyc,
	input  logic                      dl_stb,
	input  logic                      dl_we,
	input  logic [23:0]               dl_adr,
	input  logic [15:0]               dl_dat,
	output logic                      dl_ack,
	input  logic                      dl_active,
	input  logic                      dl_cart,
	// Time-register port
	input  logic                      tr_cyc,
	input  logic                      tr_stb,
	input  logic                      tr_we,
	input  cart_map_pkg::reg_offset_t tr_adr,
	input  logic [15:0]               tr_dat_w,
	output logic [15:0]               tr_dat_r,
	output logic                      tr_ack,
	// CPU side
	input  cart_map_pkg::cpu_addr_t   cpu_addr,
	input  logic                      cpu_strobe,
	input  logic [15:0]               rom_data_in,
	output logic [15:0]               rom_data_out,
	output cart_map_pkg::cpu_addr_t   rom_addr,
	output rom_header_pkg::region_t   region,
	output logic                      pier_quirk,
	output logic                      cart_mode,
	// EEPROM pins
	input  logic                      eeprom_so,
	output logic                      eeprom_cs,
	output logic                      eeprom_hold,
	output logic                      eeprom_sck,
	output logic                      eeprom_si
);
	import cart_map_pkg::*;

	rom_mask_t rom_mask;  // Snooper to mapper

	rom_header_snoop i_snoop (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dl_cyc     (dl_cyc),
		.dl_stb     (dl_stb),
		.dl_we      (dl_we),
		.dl_adr     (dl_adr),
		.dl_dat     (dl_dat),
		.dl_active  (dl_active),
		.dl_cart    (dl_cart),
		.dl_ack     (dl_ack),
		.region     (region),
		.pier_quirk (pier_quirk),
		.cart_mode  (cart_mode),
		.rom_mask   (rom_mask)
	);

	bank_mapper i_mapper (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.tr_cyc      (tr_cyc),
		.tr_stb      (tr_stb),
		.tr_we       (tr_we),
		.tr_adr      (tr_adr),
		.tr_dat_w    (tr_dat_w),
		.tr_dat_r    (tr_dat_r),
		.tr_ack      (tr_ack),
		.dl_active   (dl_active),
		.pier_quirk  (pier_quirk),
		.rom_mask    (rom_mask),
		.cpu_addr    (cpu_addr),
		.rom_addr    (rom_addr),
		.eeprom_so   (eeprom_so),
		.eeprom_cs   (eeprom_cs),
		.eeprom_hold (eeprom_hold),
		.eeprom_sck  (eeprom_sck),
		.eeprom_si   (eeprom_si)
	);

	pier_protect i_protect (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl_active    (dl_active),
		.pier_quirk   (pier_quirk),
		.cpu_strobe   (cpu_strobe),
		.cpu_addr     (cpu_addr),
		.rom_data_in  (rom_data_in),
		.rom_data_out (rom_data_out)
	);

endmodule

/* sim/cart_mapper_tb.sv */
`timescale 1ns/100ps
// Testbench for the cartridge mapping block
// Applies a table of download, register and CPU probe steps and checks every response

module cart_mapper_tb;
	import cart_map_pkg::*;
	import rom_header_pkg::*;

	typedef enum logic [3:0] {
		DL_BEGIN, DL_END, DL_WR, TR_WR, TR_RD, ADDR_PROBE, HOOK_PROBE,
		REGION_CHK, FLAG_CHK, PIN_CHK
	} step_kind_t;

	typedef struct packed {
		step_kind_t  kind;
		logic [23:0] addr;  // Byte address, or register offset in the low bits
		logic [15:0] data;
		logic [23:0] exp;
	} step_t;

	localparam int FILL_WORDS = 12;

	logic        clk_sys, reset;
	logic        dl_cyc, dl_stb, dl_we, dl_ack, dl_active, dl_cart;
	logic [23:0] dl_adr;
	logic [15:0] dl_dat, tr_dat_w, tr_dat_r, rom_data_in, rom_data_out;
	logic        tr_cyc, tr_stb, tr_we, tr_ack;
	reg_offset_t tr_adr;
	cpu_addr_t   cpu_addr, rom_addr;
	logic        cpu_strobe, pier_quirk, cart_mode;
	region_t     region;
	logic        eeprom_so, eeprom_cs, eeprom_hold, eeprom_sck, eeprom_si;

	step_t       steps[$];
	logic [31:0] lcg_state = 32'd99;
	int          cycle_count = 0;
	int          cycle_limit = 0;
	int          checks = 0;
	int          region_errors = 0;
	int          addr_errors = 0;
	int          word_errors = 0;

	cart_mapper_top i_cart_mapper_top (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	function automatic void add_step(input step_kind_t kind, input logic [23:0] addr,
			input logic [15:0] data, input logic [23:0] exp);
		steps.push_back('{kind, addr, data, exp});
	endfunction

	// Serial starts at image byte 0x183, the low half of a download word is the even byte
	function automatic logic [15:0] id_word(input cart_id_t id, input int k);
		logic [7:0] lo;
		logic [7:0] hi;
		lo = (k == 0) ? 8'h20 : 8'(id >> (64 - 16 * k));
		hi = 8'(id >> (56 - 16 * k));
		return {hi, lo};
	endfunction

	//////////////////////////////////////////////////
	// Compare tasks

	task automatic check_region(input region_t got, input region_t exp, input string what);
		checks++;
		if (got !== exp) begin
			region_errors++;
			$display("ERROR %0t: %s gave region %s, expected %s", $time, what, got.name(),
				exp.name());
		end
	endtask

	task automatic check_addr(input cpu_addr_t got, input cpu_addr_t exp, input string what);
		checks++;
		if (got !== exp) begin
			addr_errors++;
			$display("ERROR %0t: %s gave 0x%h, expected 0x%h", $time, what, {got, 1'b0},
				{exp, 1'b0});
		end
	endtask

	task automatic check_word(input logic [15:0] got, input logic [15:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			word_errors++;
			$display("ERROR %0t: %s gave 0x%h, expected 0x%h", $time, what, got, exp);
		end
	endtask

	//////////////////////////////////////////////////
	// Bus masters, hold the request until ack

	task automatic dl_write(input logic [23:0] adr, input logic [15:0] dat);
		@(posedge clk_sys);
		#2;
		{dl_cyc, dl_stb, dl_we} = 3'b111;
		dl_adr = adr;
		dl_dat = dat;
		@(negedge clk_sys);
		while (!dl_ack) @(negedge clk_sys);
		@(posedge clk_sys);
		#2;
		{dl_cyc, dl_stb, dl_we} = 3'b000;
		@(negedge clk_sys);
		check_word({15'd0, dl_ack}, 16'h0000, "Download ack after one cycle");
	endtask

	task automatic tr_access(input logic we, input reg_offset_t ofs, input logic [15:0] dat,
			input logic so, output logic [15:0] rd);
		@(posedge clk_sys);
		#2;
		{tr_cyc, tr_stb, tr_we} = {2'b11, we};
		tr_adr    = ofs;
		tr_dat_w  = dat;
		eeprom_so = so;
		@(negedge clk_sys);
		while (!tr_ack) @(negedge clk_sys);
		rd = tr_dat_r;  // Valid while ack is high
		@(posedge clk_sys);
		#2;
		{tr_cyc, tr_stb, tr_we} = 3'b000;
		@(negedge clk_sys);
		check_word({15'd0, tr_ack}, 16'h0000, "Register ack after one cycle");
	endtask

	task automatic run_step(input step_t s);
		logic [15:0] rd;
		case (s.kind)
			DL_BEGIN, DL_END: begin
				@(posedge clk_sys);
				#2;
				dl_active = (s.kind == DL_BEGIN);
				dl_cart   = s.data[0];
			end
			DL_WR: dl_write(s.addr, s.data);
			TR_WR: tr_access(1'b1, s.addr[2:0], s.data, 1'b0, rd);
			TR_RD: begin
				tr_access(1'b0, s.addr[2:0], 16'h0000, s.data[0], rd);
				check_word(rd, s.exp[15:0], "Register read");
			end
			ADDR_PROBE: begin
				@(posedge clk_sys);
				#2;
				cpu_addr = s.addr[23:1];
				@(negedge clk_sys);
				check_addr(rom_addr, s.exp[23:1], "Address probe");
			end
			HOOK_PROBE: begin
				@(posedge clk_sys);
				#2;
				cpu_addr    = s.addr[23:1];
				rom_data_in = s.data;
				cpu_strobe  = 1'b1;
				@(posedge clk_sys);
				#2;
				cpu_strobe = 1'b0;
				@(negedge clk_sys);
				check_word(rom_data_out, s.exp[15:0], "Hook probe");
			end
			REGION_CHK: begin
				@(negedge clk_sys);
				check_region(region, region_t'(s.exp[1:0]), "Region letter");
			end
			FLAG_CHK: begin
				@(negedge clk_sys);
				check_word({14'd0, pier_quirk, cart_mode}, s.exp[15:0], "Quirk and cart flags");
			end
			default: begin
				@(negedge clk_sys);
				check_word({12'd0, eeprom_cs, eeprom_hold, eeprom_sck, eeprom_si}, s.exp[15:0],
					"EEPROM pins");
			end
		endcase
	endtask

	//////////////////////////////////////////////////
	// Stimulus table

	function automatic void build_steps();
		logic [31:0] r;
		// Region letters J, U, E in one download
		add_step(DL_BEGIN, 24'h0, 16'h0001, 24'h0);
		add_step(DL_WR, HDR_REGION_ADDR, 16'h204A, 24'h0);
		add_step(REGION_CHK, 24'h0, 16'h0, {22'd0, JP});
		add_step(DL_WR, HDR_REGION_ADDR, 16'h2055, 24'h0);
		add_step(REGION_CHK, 24'h0, 16'h0, {22'd0, US});
		add_step(DL_WR, HDR_REGION_ADDR, 16'h2045, 24'h0);
		add_step(REGION_CHK, 24'h0, 16'h0, {22'd0, EU});
		add_step(DL_END, 24'h0, 16'h0001, 24'h0);
		// BIOS image leaves cart mode
		add_step(DL_BEGIN, 24'h0, 16'h0000, 24'h0);
		add_step(DL_WR, 24'h000000, 16'h4E71, 24'h0);
		add_step(DL_END, 24'h0, 16'h0000, 24'h0);
		add_step(FLAG_CHK, 24'h0, 16'h0, 24'h000000);
		// 4 MB image, filler kept clear of the header
		add_step(DL_BEGIN, 24'h0, 16'h0001, 24'h0);
		add_step(DL_WR, 24'h000000, 16'h4E71, 24'h0);
		for (int i = 0; i < FILL_WORDS; i++) begin
			r = lcg_next();
			add_step(DL_WR, 24'h000200 + 24'(((r >> 8) % 32'h001FFF00) << 1), r[15:0], 24'h0);
		end
		add_step(DL_WR, 24'h3FFFFE, 16'hFFFF, 24'h0);
		add_step(DL_END, 24'h0, 16'h0001, 24'h0);
		add_step(FLAG_CHK, 24'h0, 16'h0, 24'h000001);
		add_step(ADDR_PROBE, 24'h012346, 16'h0, 24'h012346);
		add_step(ADDR_PROBE, 24'h2ABCDE, 16'h0, 24'h2ABCDE);
		add_step(ADDR_PROBE, 24'h5ABCDE, 16'h0, 24'h1ABCDE);  // Slot 3, top bits folded
		add_step(ADDR_PROBE, 24'hC01234, 16'h0, 24'h001234);
		add_step(TR_WR, 24'h2, 16'h0009, 24'h0);             // No banking at 4 MB
		add_step(ADDR_PROBE, 24'h100000, 16'h0, 24'h100000);
		// 8 MB image, standard mapper
		add_step(DL_BEGIN, 24'h0, 16'h0001, 24'h0);
		add_step(DL_WR, 24'h000000, 16'h0000, 24'h0);
		add_step(DL_WR, 24'h7FFFFE, 16'h0000, 24'h0);
		add_step(DL_END, 24'h0, 16'h0001, 24'h0);
		add_step(ADDR_PROBE, 24'h100000, 16'h0, 24'h100000);
		add_step(TR_WR, 24'h2, 16'hFFE9, 24'h0);             // Bank 9 in the low five bits
		add_step(ADDR_PROBE, 24'h100000, 16'h0, 24'h480000);
		add_step(ADDR_PROBE, 24'h17FFFE, 16'h0, 24'h4FFFFE);
		add_step(TR_WR, 24'h7, 16'h001F, 24'h0);
		add_step(ADDR_PROBE, 24'h380000, 16'h0, 24'h780000);  // Bank 31 folded to 8 MB
		add_step(TR_WR, 24'h0, 16'h0009, 24'h0);
		add_step(ADDR_PROBE, 24'h000100, 16'h0, 24'h000100);
		add_step(TR_RD, 24'h2, 16'h0000, 24'h00FFFF);
		// Protected cart identity
		add_step(DL_BEGIN, 24'h0, 16'h0001, 24'h0);
		add_step(DL_WR, 24'h000000, 16'h0000, 24'h0);
		for (int k = 0; k < 5; k++)
			add_step(DL_WR, HDR_ID_FIRST + 24'(2 * k), id_word(PIER_ID_REPRINT, k), 24'h0);
		add_step(DL_WR, HDR_ID_DONE, 16'h2020, 24'h0);
		add_step(DL_WR, 24'h3FFFFE, 16'h0000, 24'h0);
		add_step(DL_END, 24'h0, 16'h0001, 24'h0);
		add_step(FLAG_CHK, 24'h0, 16'h0, 24'h000003);
		add_step(PIN_CHK, 24'h0, 16'h0, 24'h00000F);
		add_step(TR_WR, 24'h1, 16'h0013, 24'h0);             // Bank 5 gets 3, bit 4 dropped
		add_step(ADDR_PROBE, 24'h280010, 16'h0, 24'h180010);
		add_step(TR_WR, 24'h3, 16'h0006, 24'h0);
		add_step(ADDR_PROBE, 24'h380000, 16'h0, 24'h300000);
		add_step(TR_WR, {21'd0, OFS_EEPROM}, 16'h0005, 24'h0);
		add_step(PIN_CHK, 24'h0, 16'h0, 24'h000005);
		add_step(TR_RD, {21'd0, OFS_EEPROM_SO}, 16'h0000, 24'h00FFFE);
		add_step(TR_RD, {21'd0, OFS_EEPROM_SO}, 16'h0001, 24'h00FFFF);
		add_step(TR_RD, 24'h3, 16'h0000, 24'h00FFFF);
		// Protection hook, six early answers then the late one
		for (int n = 0; n < 6; n++)
			add_step(HOOK_PROBE, 24'h0015E8, 16'h1234, 24'h000010);
		add_step(HOOK_PROBE, 24'h0015E8, 16'h1234, 24'h008010);
		add_step(HOOK_PROBE, 24'h001000, 16'hBEEF, 24'h00BEEF);
		add_step(HOOK_PROBE, 24'h0015E6, 16'h1234, 24'h000001);
	endfunction

	initial begin
		{dl_cyc, dl_stb, dl_we, dl_active, dl_cart} = 5'b00000;
		dl_adr = '0;
		dl_dat = '0;
		{tr_cyc, tr_stb, tr_we} = 3'b000;
		tr_adr      = '0;
		tr_dat_w    = '0;
		cpu_addr    = '0;
		cpu_strobe  = 1'b0;
		rom_data_in = '0;
		eeprom_so   = 1'b0;
		reset       = 1'b1;
		build_steps();
		cycle_limit = steps.size() * 20;
		repeat (8) @(posedge clk_sys);
		#2 reset = 1'b0;
		foreach (steps[i])
			run_step(steps[i]);
		$display("Checks %0d, region errors %0d, address errors %0d, word errors %0d",
			checks, region_errors, addr_errors, word_errors);
		if (region_errors + addr_errors + word_errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// Run limit from the table length
	initial begin
		wait (cycle_limit != 0);
		while (cycle_count < cycle_limit) begin
			@(posedge clk_sys);
			cycle_count++;
		end
		$display("Timeout after %0d clock cycles, the DUT stopped answering", cycle_count);
		$display("Regression failed");
		$finish;
	end

endmodule

/* verilog.f */
hw/cart_map_pkg.sv
hw/rom_header_pkg.sv
hw/rom_header_snoop.sv
hw/bank_mapper.sv
hw/pier_protect.sv
hw/cart_mapper_top.sv
sim/cart_mapper_tb.sv

/* Makefile */
# Verilator flow for the cartridge mapper testbench

LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f verilog.f --top-module cart_mapper_tb
	verilator --lint-only hw/cart_map_pkg.sv hw/rom_header_pkg.sv hw/rom_header_snoop.sv \
		hw/bank_mapper.sv hw/pier_protect.sv hw/cart_mapper_top.sv --top-module cart_mapper_top

obj_dir/Vcart_mapper_tb: verilog.f hw/*.sv sim/*.sv
	verilator --binary --timing -f verilog.f --top-module cart_mapper_tb

sim: obj_dir/Vcart_mapper_tb
	./obj_dir/Vcart_mapper_tb | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
